// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_exec
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rv_alu.sv ====
/*
  rv32i integer alu
  add, sub, logic ops, signed and unsigned compares, shifts
*/
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
  input  alu_op_t         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] y
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount from low bits only
  assign shamt = b[4:0];

  // compares
  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  //**********************************************************************
  // result mux
  //**********************************************************************
  always_comb begin
    case (op)
      alu_add: begin
        y = a + b;
      end
      alu_sub: begin
        y = a - b;
      end
      alu_sll: begin
        y = a << shamt;
      end
      alu_slt: begin
        // one or zero
        y = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        y = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      alu_xor: begin
        y = a ^ b;
      end
      alu_srl: begin
        y = a >> shamt;
      end
      alu_sra: begin
        // sign fill from a[31]
        y = $unsigned($signed(a) >>> shamt);
      end
      alu_or: begin
        y = a | b;
      end
      alu_and: begin
        y = a & b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

// ==== rv_decode.sv ====
/*
  rv32i op / op-imm decoder
  register selects, immediate, alu operation, write request, illegal flag
*/
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
  input  instr_u                instr,
  input  logic                  instr_valid,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [reg_addr_w-1:0] rd,
  output alu_op_t               alu_op,
  output logic [xlen-1:0]       imm,
  output logic                  use_imm,
  output logic                  wr_req,
  output logic                  illegal_op
);

  logic       is_op;
  logic       is_op_imm;
  logic [2:0] funct3;
  logic       funct7_alt;

  //**********************************************************************
  // format detect
  //**********************************************************************
  // opcode sits in the same bits for both views
  assign is_op     = (instr.r.opcode == opc_op);
  assign is_op_imm = (instr.i.opcode == opc_op_imm);

  //**********************************************************************
  // field extraction
  //**********************************************************************
  always_comb begin
    // rs1, rd and funct3 share their bits in both views
    rs1        = instr.r.rs1;
    rs2        = instr.r.rs2;
    rd         = instr.r.rd;
    funct3     = instr.r.funct3;
    // upper imm bits of srai line up with funct7
    funct7_alt = (instr.r.funct7 == f7_alt);
    if (is_op_imm) begin
      // i view, no second source
      rs2 = '0;
    end
  end

  // sign extended i immediate
  assign imm     = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
  assign use_imm = is_op_imm;

  //**********************************************************************
  // alu operation
  //**********************************************************************
  always_comb begin
    case (funct3)
      f3_add: begin
        // addi has no sub form
        if (is_op && funct7_alt) begin
          alu_op = alu_sub;
        end else begin
          alu_op = alu_add;
        end
      end
      f3_sll:  alu_op = alu_sll;
      f3_slt:  alu_op = alu_slt;
      f3_sltu: alu_op = alu_sltu;
      f3_xor:  alu_op = alu_xor;
      f3_sr: begin
        if (funct7_alt) begin
          alu_op = alu_sra;
        end else begin
          alu_op = alu_srl;
        end
      end
      f3_or:   alu_op = alu_or;
      f3_and:  alu_op = alu_and;
      default: alu_op = alu_add;
    endcase
  end

  //**********************************************************************
  // issue qualifiers
  //**********************************************************************
  assign wr_req     = instr_valid && (is_op || is_op_imm);
  assign illegal_op = instr_valid && !(is_op || is_op_imm);

endmodule

// ==== rv_exec_assert.sv ====
/*
  rv32i execute slice result port assertions
  flag exclusivity, reset state, result payload hold
*/
`timescale 1ns/1ns

module rv_exec_assert (
  input logic       clk,
  input logic       arst_n,
  input logic       result_valid,
  input logic       illegal,
  input logic [4:0] result_rd
);

  // one kind of report per cycle
  assert property (@(posedge clk) disable iff (!arst_n) !(result_valid && illegal))
    else $error("result_valid and illegal high together");

  // flags cleared while reset is held
  assert property (@(posedge clk) !arst_n |-> (!result_valid && !illegal))
    else $error("result flags high during reset");

  // destination known whenever reported
  assert property (@(posedge clk) disable iff (!arst_n) result_valid |-> !$isunknown(result_rd))
    else $error("result_rd unknown while result_valid");

  // payload holds once the valid pulse ends
  assert property (@(posedge clk) disable iff (!arst_n)
                   ($past(result_valid) && !result_valid) |-> $stable(result_rd))
    else $error("result_rd changed without a new result");

endmodule

bind rv_exec_top rv_exec_assert assert_i (
  .clk          (clk),
  .arst_n       (arst_n),
  .result_valid (result_valid),
  .illegal      (illegal),
  .result_rd    (result_rd)
);

// ==== rv_exec_top.sv ====
/*
  rv32i execute slice top
  decode, register file and alu with a registered result port
*/
`timescale 1ns/1ns

module rv_exec_top import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  // issue, one word per cycle, no ready
  input  logic                  instr_valid,
  input  instr_u                instr,
  // load return
  input  logic                  load_valid,
  input  logic [reg_addr_w-1:0] load_rd,
  input  logic [xlen-1:0]       load_data,
  // retire report
  output logic                  result_valid,
  output logic [reg_addr_w-1:0] result_rd,
  output logic [xlen-1:0]       result_data,
  output logic                  illegal
);

  logic [reg_addr_w-1:0] rs1_sel;
  logic [reg_addr_w-1:0] rs2_sel;
  logic [reg_addr_w-1:0] rd_sel;
  alu_op_t               alu_op;
  logic [xlen-1:0]       imm;
  logic                  use_imm;
  logic                  wr_req;
  logic                  illegal_op;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       alu_b;
  logic [xlen-1:0]       alu_y;

  //**********************************************************************
  // decode
  //**********************************************************************
  rv_decode decode_i (
    .instr       (instr),
    .instr_valid (instr_valid),
    .rs1         (rs1_sel),
    .rs2         (rs2_sel),
    .rd          (rd_sel),
    .alu_op      (alu_op),
    .imm         (imm),
    .use_imm     (use_imm),
    .wr_req      (wr_req),
    .illegal_op  (illegal_op)
  );

  //**********************************************************************
  // register file
  //**********************************************************************
  // alu result on port one so it beats a colliding load
  rv_regfile regfile_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .sel_a    (rs1_sel),
    .sel_b    (rs2_sel),
    .data_a   (rs1_data),
    .data_b   (rs2_data),
    .sel_wr   (rd_sel),
    .wr_en    (wr_req),
    .wr_data  (alu_y),
    .sel_wr2  (load_rd),
    .wr2_en   (load_valid),
    .wr2_data (load_data)
  );

  //**********************************************************************
  // execute
  //**********************************************************************
  // op-imm takes the immediate as b
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu alu_i (
    .op (alu_op),
    .a  (rs1_data),
    .b  (alu_b),
    .y  (alu_y)
  );

  //**********************************************************************
  // result port
  //**********************************************************************
  // flags, one cycle pulse per instruction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      result_valid <= wr_req;
      illegal      <= illegal_op;
    end
  end

  // payload, held between legal instructions
  always_ff @(posedge clk) begin
    if (wr_req) begin
      result_rd   <= rd_sel;
      result_data <= alu_y;
    end
  end

endmodule

// ==== rv_pkg.sv ====
/*
  rv32i execute slice shared definitions
  widths, opcode and funct encodings, alu operations, instruction views
*/
package rv_pkg;

  //**********************************************************************
  // widths
  //**********************************************************************
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  //**********************************************************************
  // major opcodes
  //**********************************************************************
  // register-register
  localparam logic [6:0] opc_op     = 7'b0110011;
  // register-immediate
  localparam logic [6:0] opc_op_imm = 7'b0010011;

  // funct3 field values
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct7 picking sub / sra
  localparam logic [6:0] f7_alt = 7'b0100000;

  //**********************************************************************
  // alu operations
  //**********************************************************************
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_t;

  // one instruction word, seen as r-type or as i-type
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } instr_u;

endpackage

// ==== rv_regfile.sv ====
/*
  rv32i register file, 32 entries
  two combinational reads, two prioritized write ports, x0 reads zero
*/
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  // read ports
  input  logic [reg_addr_w-1:0] sel_a,
  input  logic [reg_addr_w-1:0] sel_b,
  output logic [xlen-1:0]       data_a,
  output logic [xlen-1:0]       data_b,
  // first write port, alu side
  input  logic [reg_addr_w-1:0] sel_wr,
  input  logic                  wr_en,
  input  logic [xlen-1:0]       wr_data,
  // second write port, load return
  input  logic [reg_addr_w-1:0] sel_wr2,
  input  logic                  wr2_en,
  input  logic [xlen-1:0]       wr2_data
);

  //**********************************************************************
  // storage
  //**********************************************************************
  // x0 has no storage
  logic [xlen-1:0] regs [1:num_regs-1];

  //**********************************************************************
  // read ports
  //**********************************************************************
  always_comb begin
    if (sel_a == '0) begin
      data_a = '0;
    end else begin
      data_a = regs[sel_a];
    end
  end

  always_comb begin
    if (sel_b == '0) begin
      data_b = '0;
    end else begin
      data_b = regs[sel_b];
    end
  end

  //**********************************************************************
  // write ports
  //**********************************************************************
  // per entry select
  // port one first, load port only if port one misses this entry
  // select zero never matches an entry so x0 writes vanish
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < num_regs; i++) begin
        if (wr_en && (sel_wr == reg_addr_w'(i))) begin
          regs[i] <= wr_data;
        end else if (wr2_en && (sel_wr2 == reg_addr_w'(i))) begin
          regs[i] <= wr2_data;
        end
      end
    end
  end

endmodule

// ==== src.f ====
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_alu.sv
rv_exec_top.sv
rv_exec_assert.sv
tb_rv_exec.sv

// ==== tb_rv_exec.sv ====
/*
  testbench for the rv32i execute slice
  table driven issue and load stimulus checked against a register model
*/
`timescale 1ns/1ns

module tb_rv_exec import rv_pkg::*; ();

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr_word;
  logic        load_valid;
  logic [4:0]  load_rd;
  logic [31:0] load_data;
  logic        result_valid;
  logic [4:0]  result_rd;
  logic [31:0] result_data;
  logic        illegal;

  // stimulus table and expected response per entry
  logic [31:0] tbl_instr [$];
  logic        tbl_lv [$];
  logic [4:0]  tbl_lrd [$];
  logic [31:0] tbl_ldata [$];
  logic        exp_legal [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];

  logic [31:0] model_regs [0:31];
  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  int          cycles = 0;
  int          limit = 0;

  rv_exec_top dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr_word),
    .load_valid   (load_valid),
    .load_rd      (load_rd),
    .load_data    (load_data),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit from table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run passed %0d cycles without finishing", limit);
      $display("Regression failed");
      $finish;
    end
  end

  //**********************************************************************
  // random source, fibonacci lfsr taps 32 22 2 1
  //**********************************************************************
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] v;
    v = rand_bits(5);
    return v[4:0];
  endfunction

  function automatic logic [11:0] rand_imm();
    logic [31:0] v;
    v = rand_bits(12);
    return v[11:0];
  endfunction

  //**********************************************************************
  // instruction encoders
  //**********************************************************************
  function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] op_imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  // addi r, r, 0 reads a register back
  function automatic logic [31:0] readback(input logic [4:0] r);
    return op_imm_word(12'h000, r, f3_add, r);
  endfunction

  //**********************************************************************
  // reference model
  //**********************************************************************
  function automatic logic [31:0] model_exec(input logic [31:0] word);
    logic        is_op;
    logic        alt;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic [31:0] res;
    is_op = (word[6:0] == opc_op);
    alt   = (word[31:25] == f7_alt);
    a     = model_regs[word[19:15]];
    if (is_op) begin
      b = model_regs[word[24:20]];
    end else begin
      b = {{20{word[31]}}, word[31:20]};
    end
    sh = b[4:0];
    case (word[14:12])
      f3_add:  res = (is_op && alt) ? a - b : a + b;
      f3_sll:  res = a << sh;
      // signed order by flipping the sign bits
      f3_slt:  res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      f3_sltu: res = (a < b) ? 32'd1 : 32'd0;
      f3_xor:  res = a ^ b;
      f3_sr: begin
        res = a >> sh;
        // arithmetic form refills the vacated top bits
        if (alt && a[31]) begin
          res = res | ~(32'hffff_ffff >> sh);
        end
      end
      f3_or:   res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // load lands first, a legal alu write to the same register replaces it
  task automatic add_entry(input logic [31:0] word, input logic lv, input logic [4:0] lrd,
                           input logic [31:0] ldata);
    logic        legal;
    logic [31:0] val;
    legal = (word[6:0] == opc_op) || (word[6:0] == opc_op_imm);
    val   = legal ? model_exec(word) : 32'h0;
    tbl_instr.push_back(word);
    tbl_lv.push_back(lv);
    tbl_lrd.push_back(lrd);
    tbl_ldata.push_back(ldata);
    exp_legal.push_back(legal);
    exp_rd.push_back(word[11:7]);
    exp_data.push_back(val);
    if (lv && lrd != 5'd0) begin
      model_regs[lrd] = ldata;
    end
    if (legal && word[11:7] != 5'd0) begin
      model_regs[word[11:7]] = val;
    end
  endtask

  task automatic add_random_op(input int kind);
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [11:0] imm;
    logic [31:0] word;
    rs1 = rand_reg();
    rs2 = rand_reg();
    rd  = rand_reg();
    imm = rand_imm();
    case (kind)
      0:  word = op_word(7'd0, rs2, rs1, f3_add, rd);
      1:  word = op_word(f7_alt, rs2, rs1, f3_add, rd);
      2:  word = op_word(7'd0, rs2, rs1, f3_sll, rd);
      3:  word = op_word(7'd0, rs2, rs1, f3_slt, rd);
      4:  word = op_word(7'd0, rs2, rs1, f3_sltu, rd);
      5:  word = op_word(7'd0, rs2, rs1, f3_xor, rd);
      6:  word = op_word(7'd0, rs2, rs1, f3_sr, rd);
      7:  word = op_word(f7_alt, rs2, rs1, f3_sr, rd);
      8:  word = op_word(7'd0, rs2, rs1, f3_or, rd);
      9:  word = op_word(7'd0, rs2, rs1, f3_and, rd);
      10: word = op_imm_word(imm, rs1, f3_add, rd);
      11: word = op_imm_word(imm, rs1, f3_slt, rd);
      12: word = op_imm_word(imm, rs1, f3_sltu, rd);
      13: word = op_imm_word(imm, rs1, f3_xor, rd);
      14: word = op_imm_word(imm, rs1, f3_or, rd);
      15: word = op_imm_word(imm, rs1, f3_and, rd);
      16: word = op_imm_word({7'd0, imm[4:0]}, rs1, f3_sll, rd);
      17: word = op_imm_word({7'd0, imm[4:0]}, rs1, f3_sr, rd);
      default: word = op_imm_word({f7_alt, imm[4:0]}, rs1, f3_sr, rd);
    endcase
    add_entry(word, 1'b0, 5'd0, 32'd0);
  endtask

  //**********************************************************************
  // stimulus table
  //**********************************************************************
  task automatic build_table();
    logic [31:0] nop;
    logic [31:0] word;
    nop = op_imm_word(12'h000, 5'd0, f3_add, 5'd0);
    // every register reads zero after reset
    for (int r = 0; r < 32; r++) begin
      add_entry(readback(5'(r)), 1'b0, 5'd0, 32'd0);
    end
    // load each register, read it back on the next entry
    for (int r = 1; r < 32; r++) begin
      word = (r == 1) ? nop : readback(5'(r - 1));
      add_entry(word, 1'b1, 5'(r), rand_bits(32));
    end
    add_entry(readback(5'd31), 1'b1, 5'd0, rand_bits(32));
    add_entry(readback(5'd0), 1'b0, 5'd0, 32'd0);
    // negative operand, shifts, compares, negative immediates
    add_entry(nop, 1'b1, 5'd20, 32'hf0f0_1234);
    add_entry(op_imm_word({f7_alt, 5'd4}, 5'd20, f3_sr, 5'd21), 1'b0, 5'd0, 32'd0);
    add_entry(op_imm_word({7'd0, 5'd4}, 5'd20, f3_sr, 5'd22), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(f7_alt, 5'd2, 5'd20, f3_sr, 5'd23), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(f7_alt, 5'd20, 5'd0, f3_add, 5'd24), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(7'd0, 5'd1, 5'd20, f3_slt, 5'd25), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(7'd0, 5'd1, 5'd20, f3_sltu, 5'd26), 1'b0, 5'd0, 32'd0);
    add_entry(op_imm_word(12'hffb, 5'd20, f3_slt, 5'd27), 1'b0, 5'd0, 32'd0);
    add_entry(op_imm_word(12'hfff, 5'd1, f3_sltu, 5'd28), 1'b0, 5'd0, 32'd0);
    add_entry(op_imm_word(12'h800, 5'd1, f3_add, 5'd29), 1'b0, 5'd0, 32'd0);
    for (int rep = 0; rep < 2; rep++) begin
      for (int kind = 0; kind < 19; kind++) begin
        add_random_op(kind);
      end
    end
    // dependent chain, x0 as destination then as source
    add_entry(op_imm_word(12'h123, 5'd0, f3_add, 5'd5), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(7'd0, 5'd5, 5'd5, f3_add, 5'd6), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(f7_alt, 5'd5, 5'd6, f3_add, 5'd7), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(7'd0, 5'd6, 5'd7, f3_xor, 5'd0), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(7'd0, 5'd7, 5'd0, f3_add, 5'd8), 1'b0, 5'd0, 32'd0);
    add_entry(op_word(7'd0, 5'd0, 5'd8, f3_or, 5'd9), 1'b0, 5'd0, 32'd0);
    // same edge writes, same and different targets
    add_entry(op_imm_word(12'h055, 5'd0, f3_add, 5'd10), 1'b1, 5'd10, rand_bits(32));
    add_entry(readback(5'd10), 1'b0, 5'd0, 32'd0);
    add_entry(op_imm_word(12'hfff, 5'd0, f3_add, 5'd11), 1'b1, 5'd12, rand_bits(32));
    add_entry(readback(5'd11), 1'b0, 5'd0, 32'd0);
    add_entry(readback(5'd12), 1'b0, 5'd0, 32'd0);
    // illegal opcodes leave the target untouched
    word = rand_bits(32);
    add_entry({word[31:12], 5'd13, 7'b0000011}, 1'b0, 5'd0, 32'd0);
    add_entry(readback(5'd13), 1'b0, 5'd0, 32'd0);
    add_entry({word[31:12], 5'd14, 7'b1101111}, 1'b0, 5'd0, 32'd0);
    add_entry(readback(5'd14), 1'b0, 5'd0, 32'd0);
  endtask

  //**********************************************************************
  // response check
  //**********************************************************************
  task automatic check_entry(input int k);
    checks++;
    if (exp_legal[k]) begin
      if (result_valid !== 1'b1 || illegal !== 1'b0) begin
        errors++;
        $display("error @%0t: entry %0d valid %b illegal %b, expected 1 0",
                 $time, k, result_valid, illegal);
      end else if (result_rd !== exp_rd[k] || result_data !== exp_data[k]) begin
        errors++;
        $display("error @%0t: entry %0d rd %0d data %h, expected rd %0d data %h",
                 $time, k, result_rd, result_data, exp_rd[k], exp_data[k]);
      end
    end else begin
      if (result_valid !== 1'b0 || illegal !== 1'b1) begin
        errors++;
        $display("error @%0t: entry %0d valid %b illegal %b, expected 0 1",
                 $time, k, result_valid, illegal);
      end
    end
  endtask

  task automatic check_quiet(input string where);
    checks++;
    if (result_valid !== 1'b0 || illegal !== 1'b0) begin
      errors++;
      $display("error @%0t: %s, valid %b illegal %b, expected both low",
               $time, where, result_valid, illegal);
    end
  endtask

  //**********************************************************************
  // main sequence
  //**********************************************************************
  initial begin
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr_word  = '0;
    load_valid  = 1'b0;
    load_rd     = '0;
    load_data   = '0;
    checks      = 0;
    errors      = 0;
    lfsr_state  = 32'ha9e3455a;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    build_table();
    limit = tbl_instr.size() + 20;

    repeat (3) begin
      @(negedge clk);
      check_quiet("during reset");
    end
    @(posedge clk);
    arst_n <= 1'b1;

    // entry k goes out at one edge, is taken at the next, checked half a cycle later
    for (int k = 0; k <= tbl_instr.size(); k++) begin
      @(posedge clk);
      if (k < tbl_instr.size()) begin
        instr_valid <= 1'b1;
        instr_word  <= tbl_instr[k];
        load_valid  <= tbl_lv[k];
        load_rd     <= tbl_lrd[k];
        load_data   <= tbl_ldata[k];
      end else begin
        instr_valid <= 1'b0;
        load_valid  <= 1'b0;
      end
      @(negedge clk);
      if (k > 0) begin
        check_entry(k - 1);
      end
    end
    @(negedge clk);
    check_quiet("idle after table");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
